/* source/mem_sys_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, block geometry and controller states
// Byte address is 16 bits, only even addresses are legal
// Fields are tag 15:11, index 10:3 and word select 2:1
// The word select also picks the memory bank
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_sys_pkg;

   // Processor side widths
   localparam int addr_w = 16;
   localparam int data_w = 16;

   // Address fields
   localparam int tag_w      = 5;
   localparam int index_w    = 8;
   localparam int word_sel_w = 2;

   // Block and memory geometry
   localparam int block_words = 4;
   localparam int num_banks   = 4;

   // Controller FSM
   typedef enum logic [2:0] {
      idle,
      compare,
      write_back,
      fill_req,
      fill_wait,
      fill_install,
      finish
   } ctrl_state_t;

endpackage

/* source/cache_array.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped cache storage, 256 lines of four 16-bit words
// Lookup outputs are combinational from the stored state
// Writes take effect at the clock edge while enable and write are high
// A compare write lands only on a hit and marks the line dirty
// A non-compare write is a fill: installs tag, valid_in, clears dirty
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_array (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                enable,
   input  logic                                comp,
   input  logic                                write,
   input  logic [mem_sys_pkg::index_w-1:0]     index,
   input  logic [mem_sys_pkg::tag_w-1:0]       tag_in,
   input  logic [mem_sys_pkg::word_sel_w-1:0]  word_sel,
   input  logic [mem_sys_pkg::data_w-1:0]      cache_wdata,
   input  logic                                valid_in,
   output logic                                hit,
   output logic                                dirty,
   output logic                                valid,
   output logic [mem_sys_pkg::tag_w-1:0]       tag_out,
   output logic [mem_sys_pkg::data_w-1:0]      cache_rdata
);
   import mem_sys_pkg::*;

   localparam int num_lines = 2 ** index_w;

   // Line storage
   logic [tag_w-1:0]     tag_q  [num_lines];
   logic [data_w-1:0]    data_q [num_lines][block_words];
   logic [num_lines-1:0] valid_q;
   logic [num_lines-1:0] dirty_q;

   logic tag_match;
   // Fill write, no tag check
   logic wr_fill;
   // Word write, either fill or compare hit
   logic wr_word;

   assign tag_match = (tag_q[index] == tag_in);

   // Lookup at the addressed line
   assign valid       = valid_q[index];
   assign dirty       = dirty_q[index];
   assign tag_out     = tag_q[index];
   assign hit         = comp && valid_q[index] && tag_match;
   assign cache_rdata = data_q[index][word_sel];

   assign wr_fill = enable && write && !comp;
   assign wr_word = enable && write && (!comp || hit);

   // Line state bits, cleared by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_fill) begin
         valid_q[index] <= valid_in;
         dirty_q[index] <= 1'b0;
      end else if (wr_word) begin
         // Compare write hit
         dirty_q[index] <= 1'b1;
      end
   end

   // Tag and data payload
   always_ff @(posedge clk) begin
      if (wr_fill) begin
         tag_q[index] <= tag_in;
      end
      if (wr_word) begin
         data_q[index][word_sel] <= cache_wdata;
      end
   end

endmodule

/* source/banked_mem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slow main memory, 32K words in four banks picked by the word select
// A bank is busy for bank_busy_cycles after each accepted access
// mem_stall shows the busy state of the bank that mem_addr selects
// Read data is on mem_rdata two register stages after the accept edge
// Contents start as each word's own word address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module banked_mem #(
   parameter int bank_busy_cycles = 4
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [mem_sys_pkg::addr_w-1:0]  mem_addr,
   input  logic [mem_sys_pkg::data_w-1:0]  mem_wdata,
   input  logic                            mem_rd,
   input  logic                            mem_wr,
   output logic [mem_sys_pkg::data_w-1:0]  mem_rdata,
   output logic                            mem_stall
);
   import mem_sys_pkg::*;

   // Words per bank is 2**row_w
   localparam int row_w = addr_w - 1 - word_sel_w;
   localparam int cnt_w = $clog2(bank_busy_cycles + 1);

   logic [data_w-1:0] bank_mem [num_banks][2 ** row_w];
   logic [cnt_w-1:0]  busy_cnt [num_banks];

   logic [word_sel_w-1:0] bank;
   logic [row_w-1:0]      row;
   logic                  accept_rd;
   logic                  accept_wr;

   // Read pipeline stages
   logic [data_w-1:0] rd_s0;
   logic [data_w-1:0] rd_s1;

   // Byte address to bank and row
   assign bank = mem_addr[word_sel_w:1];
   assign row  = mem_addr[addr_w-1:word_sel_w+1];

   assign mem_stall = (busy_cnt[bank] != '0);
   assign accept_rd = mem_rd && !mem_stall;
   assign accept_wr = mem_wr && !mem_stall;

   // Word address as the initial value
   initial begin
      for (int b = 0; b < num_banks; b++) begin
         for (int r = 0; r < 2 ** row_w; r++) begin
            bank_mem[b][r] = data_w'((r * num_banks) + b);
         end
      end
   end

   // Busy timers, one per bank, all banks run in parallel
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < num_banks; b++) begin
            if ((accept_rd || accept_wr) && (bank == word_sel_w'(b))) begin
               busy_cnt[b] <= cnt_w'(bank_busy_cycles);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Array access and read pipe
   always_ff @(posedge clk) begin
      if (accept_wr) begin
         bank_mem[bank][row] <= mem_wdata;
      end
      if (accept_rd) begin
         rd_s0 <= bank_mem[bank][row];
      end
      rd_s1 <= rd_s0;
   end

   assign mem_rdata = rd_s1;

endmodule

/* source/cache_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache controller FSM, one request in flight
// rd and wr are one-cycle strobes, looked at only in idle
// Illegal requests (rd with wr, odd address) finish at once with err
// Miss path: optional write-back of a dirty victim, then a 4-word fill
// Every legal request ends as a compare access in finish
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_ctrl (
   input  logic                                clk,
   input  logic                                rst,
   // Processor side
   input  logic [mem_sys_pkg::addr_w-1:0]      addr,
   input  logic [mem_sys_pkg::data_w-1:0]      data_in,
   input  logic                                rd,
   input  logic                                wr,
   output logic [mem_sys_pkg::data_w-1:0]      data_out,
   output logic                                done,
   output logic                                stall,
   output logic                                cache_hit,
   output logic                                err,
   // Cache side
   input  logic                                hit,
   input  logic                                dirty,
   input  logic                                valid,
   input  logic [mem_sys_pkg::tag_w-1:0]       tag_out,
   input  logic [mem_sys_pkg::data_w-1:0]      cache_rdata,
   output logic                                enable,
   output logic                                comp,
   output logic                                write,
   output logic [mem_sys_pkg::index_w-1:0]     index,
   output logic [mem_sys_pkg::tag_w-1:0]       tag_in,
   output logic [mem_sys_pkg::word_sel_w-1:0]  word_sel,
   output logic [mem_sys_pkg::data_w-1:0]      cache_wdata,
   output logic                                valid_in,
   // Memory side
   input  logic [mem_sys_pkg::data_w-1:0]      mem_rdata,
   input  logic                                mem_stall,
   output logic [mem_sys_pkg::addr_w-1:0]      mem_addr,
   output logic [mem_sys_pkg::data_w-1:0]      mem_wdata,
   output logic                                mem_rd,
   output logic                                mem_wr
);
   import mem_sys_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nx;

   // Latched request
   logic [addr_w-1:0] req_addr;
   logic [data_w-1:0] req_data;
   logic              req_wr;
   logic              req_err;
   logic              was_hit;

   // Word walk for write-back and fill
   logic [word_sel_w-1:0] word_cnt;

   logic                  strobe;
   logic                  illegal;
   logic [tag_w-1:0]      req_tag;
   logic [index_w-1:0]    req_index;
   logic [word_sel_w-1:0] req_word;

   assign strobe  = rd || wr;
   assign illegal = (rd && wr) || addr[0];

   assign req_tag   = req_addr[addr_w-1:addr_w-tag_w];
   assign req_index = req_addr[addr_w-tag_w-1:word_sel_w+1];
   assign req_word  = req_addr[word_sel_w:1];

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= idle;
         word_cnt <= '0;
         req_wr   <= 1'b0;
         req_err  <= 1'b0;
         was_hit  <= 1'b0;
      end else begin
         state <= state_nx;
         case (state)
            idle: begin
               if (strobe) begin
                  req_wr  <= wr;
                  req_err <= illegal;
                  was_hit <= 1'b0;
               end
            end
            // Hit flag for the finish cycle
            compare: was_hit <= hit;
            write_back: begin
               if (!mem_stall) begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            // Wraps back to zero after the last word
            fill_install: word_cnt <= word_cnt + 1'b1;
            default: ;
         endcase
      end
   end

   // Request address and data
   always_ff @(posedge clk) begin
      if ((state == idle) && strobe) begin
         req_addr <= addr;
         req_data <= data_in;
      end
   end

   // Next state
   always_comb begin
      state_nx = state;
      case (state)
         idle: begin
            if (strobe) begin
               state_nx = illegal ? finish : compare;
            end
         end
         compare: begin
            if (hit) begin
               state_nx = finish;
            end else if (valid && dirty) begin
               state_nx = write_back;
            end else begin
               state_nx = fill_req;
            end
         end
         write_back: begin
            if (!mem_stall && (word_cnt == '1)) begin
               state_nx = fill_req;
            end
         end
         fill_req: begin
            if (!mem_stall) begin
               state_nx = fill_wait;
            end
         end
         // Read data arrives here
         fill_wait: state_nx = fill_install;
         fill_install: state_nx = (word_cnt == '1) ? finish : fill_req;
         finish: state_nx = idle;
         default: state_nx = idle;
      endcase
   end

   // Cache and memory controls
   always_comb begin
      enable      = 1'b0;
      comp        = 1'b0;
      write       = 1'b0;
      valid_in    = 1'b0;
      index       = req_index;
      tag_in      = req_tag;
      word_sel    = req_word;
      cache_wdata = req_data;
      mem_addr    = {req_tag, req_index, word_cnt, 1'b0};
      mem_wdata   = cache_rdata;
      mem_rd      = 1'b0;
      mem_wr      = 1'b0;
      case (state)
         compare: begin
            // Lookup only
            enable = 1'b1;
            comp   = 1'b1;
         end
         write_back: begin
            // Victim word goes out at its own tag
            enable   = 1'b1;
            word_sel = word_cnt;
            mem_addr = {tag_out, req_index, word_cnt, 1'b0};
            mem_wr   = 1'b1;
         end
         // Held until the bank is free
         fill_req: mem_rd = 1'b1;
         fill_install: begin
            enable      = 1'b1;
            write       = 1'b1;
            valid_in    = 1'b1;
            word_sel    = word_cnt;
            cache_wdata = mem_rdata;
         end
         finish: begin
            // Replay as a hit, write merges its word
            enable = !req_err;
            comp   = 1'b1;
            write  = req_wr;
         end
         default: ;
      endcase
   end

   // Processor outputs
   assign done      = (state == finish);
   assign err       = (state == finish) && req_err;
   assign cache_hit = (state == finish) && was_hit && !req_err;
   assign stall     = (state != idle) && (state != finish);
   assign data_out  = ((state == finish) && !req_wr && !req_err) ? cache_rdata : '0;

endmodule

/* source/mem_system.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory subsystem, write-back write-allocate direct-mapped cache
// Requests are legal only while stall and done are both low
// Hits finish two cycles after the strobe, misses take longer
// bank_busy_cycles must be 1 or more
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_system #(
   parameter int bank_busy_cycles = 4
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [mem_sys_pkg::addr_w-1:0]  addr,
   input  logic [mem_sys_pkg::data_w-1:0]  data_in,
   input  logic                            rd,
   input  logic                            wr,
   output logic [mem_sys_pkg::data_w-1:0]  data_out,
   output logic                            done,
   output logic                            stall,
   output logic                            cache_hit,
   output logic                            err
);
   import mem_sys_pkg::*;

   // Controller to cache
   logic                  enable;
   logic                  comp;
   logic                  write;
   logic [index_w-1:0]    index;
   logic [tag_w-1:0]      tag_in;
   logic [word_sel_w-1:0] word_sel;
   logic [data_w-1:0]     cache_wdata;
   logic                  valid_in;
   logic                  hit;
   logic                  dirty;
   logic                  valid;
   logic [tag_w-1:0]      tag_out;
   logic [data_w-1:0]     cache_rdata;

   // Controller to memory
   logic [addr_w-1:0] mem_addr;
   logic [data_w-1:0] mem_wdata;
   logic              mem_rd;
   logic              mem_wr;
   logic [data_w-1:0] mem_rdata;
   logic              mem_stall;

   cache_ctrl ctrl_i (
      .clk, .rst, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err,
      .hit, .dirty, .valid, .tag_out, .cache_rdata,
      .enable, .comp, .write, .index, .tag_in, .word_sel, .cache_wdata, .valid_in,
      .mem_rdata, .mem_stall, .mem_addr, .mem_wdata, .mem_rd, .mem_wr
   );

   cache_array cache_i (
      .clk, .rst, .enable, .comp, .write, .index, .tag_in, .word_sel,
      .cache_wdata, .valid_in, .hit, .dirty, .valid, .tag_out, .cache_rdata
   );

   banked_mem #(
      .bank_busy_cycles(bank_busy_cycles)
   ) mem_i (
      .clk, .rst, .mem_addr, .mem_wdata, .mem_rd, .mem_wr, .mem_rdata, .mem_stall
   );

endmodule

/* dv/mem_system_sva.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions for the cache controller, bound into cache_ctrl
// Checked only while reset is low
// fail_count is read by the testbench at the end of the run
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_system_sva (
   input logic clk,
   input logic rst,
   input logic done,
   input logic stall,
   input logic mem_rd,
   input logic mem_wr
);

   int fail_count = 0;

   // done is a single-cycle pulse
   done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else begin
         $error("done high on two consecutive cycles");
         fail_count = fail_count + 1;
      end

   // Processor sees either busy or complete, never both
   stall_done_apart: assert property (@(posedge clk) disable iff (rst) !(stall && done))
      else begin
         $error("stall and done high together");
         fail_count = fail_count + 1;
      end

   // One memory command at a time
   mem_cmd_onehot: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
      else begin
         $error("mem_rd and mem_wr high together");
         fail_count = fail_count + 1;
      end

endmodule

bind cache_ctrl mem_system_sva sva_i (
   .clk, .rst, .done, .stall, .mem_rd, .mem_wr
);

/* dv/mem_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches the processor side of mem_system and checks each request
// Expectations must be valid at the strobe edge and held until done
// Latency rules: illegal 1 cycle, hit 2 cycles, miss more than 2
// max_wait bounds the cycles from strobe to done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_checker #(
   parameter int max_wait = 66
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            rd,
   input  logic                            wr,
   input  logic [mem_sys_pkg::data_w-1:0]  data_out,
   input  logic                            done,
   input  logic                            stall,
   input  logic                            cache_hit,
   input  logic                            err,
   input  logic [mem_sys_pkg::data_w-1:0]  exp_data,
   input  logic                            exp_hit,
   input  logic                            exp_err,
   output int                              errors
);
   import mem_sys_pkg::*;

   // Request in flight and what it should return
   logic              pending;
   logic              c_read;
   logic              c_hit;
   logic              c_err;
   logic [data_w-1:0] c_data;
   int                wait_cnt;
   int                req_num;
   int                lat;

   initial begin
      errors  = 0;
      req_num = 0;
   end

   always @(posedge clk) begin
      if (rst) begin
         pending  = 1'b0;
         wait_cnt = 0;
      end else begin
         if (pending) begin
            lat = wait_cnt + 1;
            if (done) begin
               pending = 1'b0;
               if (err !== c_err) begin
                  $display("MISMATCH err: got 0x%h, expected 0x%h in case %0d", err, c_err,
                           req_num);
                  errors++;
               end
               if (cache_hit !== c_hit) begin
                  $display("MISMATCH cache_hit: got 0x%h, expected 0x%h in case %0d",
                           cache_hit, c_hit, req_num);
                  errors++;
               end
               // Read data only matters on a legal read
               if (c_read && !c_err && (data_out !== c_data)) begin
                  $display("MISMATCH data_out: got 0x%h, expected 0x%h in case %0d",
                           data_out, c_data, req_num);
                  errors++;
               end
               if (c_err && (lat != 1)) begin
                  $display("ERROR: case %0d, illegal request took %0d cycles instead of 1",
                           req_num, lat);
                  errors++;
               end else if (!c_err && c_hit && (lat != 2)) begin
                  $display("ERROR: case %0d, hit took %0d cycles instead of 2", req_num, lat);
                  errors++;
               end else if (!c_err && !c_hit && (lat <= 2)) begin
                  $display("ERROR: case %0d, miss finished in only %0d cycles", req_num, lat);
                  errors++;
               end
            end else if (lat >= max_wait) begin
               $display("ERROR: case %0d got no done within %0d cycles", req_num, max_wait);
               errors++;
               pending = 1'b0;
            end else begin
               if (!stall) begin
                  $display("ERROR: case %0d, stall low while the request is in flight",
                           req_num);
                  errors++;
               end
               wait_cnt = lat;
            end
         end else if (done) begin
            $display("ERROR: done pulse with no request in flight");
            errors++;
         end else if (stall) begin
            $display("ERROR: stall high with no request in flight");
            errors++;
         end

         // New strobe, captured at its sampling edge
         if (rd || wr) begin
            if (pending) begin
               $display("ERROR: new request while case %0d is still in flight", req_num);
               errors++;
            end
            req_num++;
            pending  = 1'b1;
            wait_cnt = 0;
            c_read   = rd && !wr;
            c_hit    = exp_hit;
            c_err    = exp_err;
            c_data   = exp_data;
         end
      end
   end

endmodule

/* dv/tb_mem_system.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for mem_system, requests come from dv/mem_cases.txt
// Run from the project root so the cases file is found
// One request at a time, each waits for done, random idle gaps
// Run length is bounded by a per-case cycle budget
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_mem_system;
   import mem_sys_pkg::*;

   localparam int bank_busy_cycles = 4;
   // Worst case cycles for one request plus its idle gap
   localparam int case_budget = 8 * (bank_busy_cycles + 3) + 10;

   logic              clk;
   logic              rst;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [data_w-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   // Expectations for the checker
   logic [data_w-1:0] exp_data;
   logic              exp_hit;
   logic              exp_err;

   // Cases from the file
   int                case_op    [$];
   logic [addr_w-1:0] case_addr  [$];
   logic [data_w-1:0] case_wdata [$];
   logic [data_w-1:0] case_rdata [$];
   logic              case_hit   [$];

   int num_cases;
   int check_errors;
   int load_errors;
   int cycle_cnt;
   int cycle_limit;
   int total;

   mem_system #(
      .bank_busy_cycles(bank_busy_cycles)
   ) dut (
      .clk, .rst, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err
   );

   mem_checker #(
      .max_wait(case_budget)
   ) checker_i (
      .clk, .rst, .rd, .wr, .data_out, .done, .stall, .cache_hit, .err,
      .exp_data, .exp_hit, .exp_err, .errors(check_errors)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // Lines that do not start with a number are comments
   task automatic load_cases();
      int                fd;
      int                n;
      int                op;
      int                hit_flag;
      logic [addr_w-1:0] a;
      logic [data_w-1:0] wd;
      logic [data_w-1:0] rdv;
      string             line;
      fd = $fopen("dv/mem_cases.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open dv/mem_cases.txt");
         load_errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         n = $sscanf(line, "%h %h %h %h %h", op, a, wd, rdv, hit_flag);
         if (n == 5) begin
            case_op.push_back(op);
            case_addr.push_back(a);
            case_wdata.push_back(wd);
            case_rdata.push_back(rdv);
            case_hit.push_back(hit_flag[0]);
         end else if (n > 0) begin
            $display("ERROR: malformed line in the cases file: %s", line);
            load_errors++;
         end
      end
      $fclose(fd);
   endtask

   // Drive one request on a falling edge and wait for its done
   task automatic run_case(input int i);
      int gap;
      gap = $urandom % 4;
      @(negedge clk);
      repeat (gap) @(negedge clk);
      addr     = case_addr[i];
      data_in  = case_wdata[i];
      rd       = (case_op[i] == 1) || (case_op[i] == 3);
      wr       = (case_op[i] == 2) || (case_op[i] == 3);
      // Illegal if both strobes or an odd byte address
      exp_err  = (rd && wr) || case_addr[i][0];
      exp_hit  = case_hit[i];
      exp_data = case_rdata[i];
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
      while (!done) @(negedge clk);
   endtask

   // Run limit
   initial begin
      @(posedge clk);
      while ((cycle_limit == 0) || (cycle_cnt < cycle_limit)) @(posedge clk);
      $display("TIMEOUT: run passed %0d cycles with %0d errors so far", cycle_limit,
               check_errors + load_errors);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      rst         = 1'b1;
      rd          = 1'b0;
      wr          = 1'b0;
      addr        = '0;
      data_in     = '0;
      exp_data    = '0;
      exp_hit     = 1'b0;
      exp_err     = 1'b0;
      load_errors = 0;
      cycle_limit = 0;
      void'($urandom(32'h50760376));
      load_cases();
      num_cases = case_op.size();
      if (num_cases == 0) begin
         $display("ERROR: no cases were loaded");
         load_errors++;
      end
      cycle_limit = num_cases * case_budget;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < num_cases; i++) begin
         run_case(i);
      end
      // Let the checker sample the last done
      repeat (2) @(negedge clk);
      total = check_errors + load_errors + dut.ctrl_i.sva_i.fail_count;
      $display("Cases: %0d, checker errors: %0d, load errors: %0d, assertion failures: %0d",
               num_cases, check_errors, load_errors, dut.ctrl_i.sva_i.fail_count);
      if (total == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* build.f */
source/mem_sys_pkg.sv
source/cache_array.sv
source/banked_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
dv/mem_system_sva.sv
dv/mem_checker.sv
dv/tb_mem_system.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it
# The result is read from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_mem_system -o sim_tb \
   && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
   || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null
grep -q "^NO ERRORS$" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

/* dv/mem_cases.txt */
# op addr wdata rdata hit, all hex; op 1 read, 2 write, 3 read and write together
# rdata is the expected data_out of a legal read, hit the expected cache_hit
1 0010 0000 0008 0
1 0010 0000 0008 1
1 0012 0000 0009 1
2 0014 beef 0000 1
1 0014 0000 beef 1
1 0810 0000 0408 0
1 0014 0000 beef 0
1 0016 0000 000b 1
2 1234 cafe 0000 0
1 1234 0000 cafe 1
1 1230 0000 0918 1
1 1236 0000 091b 1
1 1232 0000 0919 1
3 0014 5555 0000 0
2 0015 6666 0000 0
1 0013 0000 0000 0
1 0014 0000 beef 1
1 0010 0000 0008 1
2 0014 1111 0000 1
2 0814 2222 0000 0
1 0816 0000 040b 1
1 0014 0000 1111 0
1 0814 0000 2222 0
1 7ffe 0000 3fff 0
1 fffe 0000 7fff 0
